// File: dv/link_checker.sv
module link_checker
    import neighbor_link_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  stage_t        global_stage,
    input  link_config_t  config_in,
    input  logic          a_increase,
    input  logic          b_increase,
    input  logic          a_is_error_in,
    input  logic          b_is_error_in,
    input  logic          is_error_systolic_in,
    input  logic          do_not_store,
    input  logic          reset_edge,
    input  exposed_data_t a_input_data,
    input  exposed_data_t b_input_data,
    input  logic          fully_grown,
    input  logic          is_boundary,
    input  logic          is_error,
    input  link_config_t  config_out,
    input  exposed_data_t a_output_data,
    input  exposed_data_t b_output_data,
    input  int            cycle_limit,
    output int            check_count,
    output int            mismatch_count,
    output int            store_count,
    output logic          timed_out
);

    stage_t        model_stage;
    link_config_t  model_cfg;
    int            model_growth;
    logic          model_error;
    int            write_slot;
    int            read_slot;
    int            cycle_count;
    int            sum;
    logic          grown;
    logic          normal;
    link_context_t saved;
    link_context_t slots [NUM_CONTEXTS];

    initial begin
        check_count    = 0;
        mismatch_count = 0;
        store_count    = 0;
        cycle_count    = 0;
        timed_out      = 1'b0;
        // context memory starts empty
        foreach (slots[i]) begin
            slots[i] = '0;
        end
    end

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
        check_count++;
        if (got !== want) begin
            mismatch_count++;
            $display("MISMATCH %s: dut 0x%0h, model 0x%0h, cycle %0d",
                     name, got, want, cycle_count);
        end
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (reset) begin
            model_stage  = STAGE_IDLE;
            model_cfg    = '0;
            model_growth = 0;
            model_error  = 1'b0;
            write_slot   = 0;
            read_slot    = 1;
        end else begin
            // outputs seen just before this edge
            grown  = (model_growth >= int'(model_cfg.weight))
                  && (model_cfg.boundary != BOUNDARY_ABSENT);
            normal = (model_cfg.boundary == BOUNDARY_NONE);
            compare_value("config_out", 32'(config_out), 32'(model_cfg));
            compare_value("fully_grown", 32'(fully_grown), 32'(grown));
            compare_value("is_boundary", 32'(is_boundary), 32'(grown
                          && (model_cfg.boundary inside {BOUNDARY_TOUCH, BOUNDARY_FUSION})));
            compare_value("is_error", 32'(is_error), 32'(model_error));
            compare_value("a_output_data", 32'(a_output_data),
                          normal ? 32'(b_input_data) : 32'(0));
            compare_value("b_output_data", 32'(b_output_data),
                          normal ? 32'(a_input_data) : 32'(0));

            if (model_stage == STAGE_WRITE_TO_MEM && !do_not_store) begin
                // save this round and bring back the slot one ahead of it
                store_count++;
                saved = '{growth: LINK_BIT_WIDTH'(model_growth), is_error: model_error};
                model_growth = int'(slots[read_slot].growth);
                model_error  = slots[read_slot].is_error;
                slots[write_slot] = saved;
                write_slot = (write_slot + 1) % NUM_CONTEXTS;
                read_slot  = (read_slot + 1) % NUM_CONTEXTS;
            end else if (model_stage == STAGE_WRITE_TO_MEM) begin
                model_growth = reset_edge ? 0 : model_growth;
                model_error  = 1'b0;
            end else begin
                case (model_cfg.boundary)
                    BOUNDARY_NONE, BOUNDARY_FUSION: begin
                        sum = model_growth + int'(a_increase) + int'(b_increase);
                    end
                    BOUNDARY_TOUCH: begin
                        sum = model_growth + int'(a_increase);
                    end
                    default: begin
                        sum = 0;
                    end
                endcase
                if (sum > int'(model_cfg.weight)) begin
                    sum = int'(model_cfg.weight);
                end
                model_growth = reset_edge ? 0 : sum;
                if (model_cfg.boundary == BOUNDARY_ABSENT) begin
                    model_error = 1'b0;
                end else if (model_stage == STAGE_RESULT_VALID) begin
                    model_error = is_error_systolic_in;
                end else begin
                    // b end only counts between two real PEs
                    model_error = a_is_error_in
                                | (b_is_error_in & (model_cfg.boundary != BOUNDARY_TOUCH));
                end
            end
            model_stage = global_stage;
            model_cfg   = config_in;
        end
        if (cycle_limit > 0 && cycle_count >= cycle_limit && !timed_out) begin
            $display("timeout: stimulus still running after %0d cycles", cycle_count);
            timed_out = 1'b1;
        end
    end

endmodule

// File: dv/neighbor_link_tb.sv
module neighbor_link_tb
    import neighbor_link_pkg::*;
();

    localparam int RESET_CYCLES  = 4;
    localparam int NUM_PHASES    = 80;
    localparam int MAX_PHASE_LEN = 8;
    localparam int DRAIN_CYCLES  = 4;

    logic          clk;
    logic          reset;
    stage_t        global_stage;
    link_config_t  config_in;
    logic          a_increase, b_increase;
    logic          a_is_error_in, b_is_error_in, is_error_systolic_in;
    logic          do_not_store, reset_edge;
    exposed_data_t a_input_data, b_input_data;
    logic          fully_grown, is_boundary, is_error;
    link_config_t  config_out;
    exposed_data_t a_output_data, b_output_data;
    int            cycle_limit;
    int            check_count, mismatch_count, store_count;
    logic          timed_out;

    neighbor_link UUT (.*);

    link_checker u_checker (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic chance(input int unsigned percent);
        return ($urandom_range(0, 99) < percent);
    endfunction

    task automatic drive_cycle(input stage_t stage, input link_config_t cfg);
        @(negedge clk);
        global_stage         <= stage;
        config_in            <= cfg;
        a_increase           <= chance(50);
        b_increase           <= chance(50);
        a_is_error_in        <= chance(30);
        b_is_error_in        <= chance(30);
        is_error_systolic_in <= chance(50);
        do_not_store         <= chance(30);
        reset_edge           <= chance(10);
        a_input_data <= '{ADDRESS_WIDTH'($urandom), 1'($urandom), 1'($urandom), 1'($urandom)};
        b_input_data <= '{ADDRESS_WIDTH'($urandom), 1'($urandom), 1'($urandom), 1'($urandom)};
    endtask

    task automatic finish_run();
        int other_errors;
        other_errors = timed_out ? 1 : 0;
        if (store_count < NUM_CONTEXTS) begin
            $display("only %0d storing context switches, too few to reload a saved context",
                     store_count);
            other_errors++;
        end
        $display("checks %0d, mismatches %0d, other errors %0d",
                 check_count, mismatch_count, other_errors);
        if (mismatch_count + other_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    endtask

    initial begin
        logic         last_was_write;
        stage_t       stage;
        link_config_t cfg;
        int           len;
        void'($urandom(8));
        reset        = 1'b1;
        global_stage = STAGE_IDLE;
        config_in    = '0;
        {a_increase, b_increase, a_is_error_in, b_is_error_in} = '0;
        {is_error_systolic_in, do_not_store, reset_edge} = '0;
        a_input_data = '0;
        b_input_data = '0;
        // four times the longest possible schedule
        cycle_limit = 4 * (RESET_CYCLES + NUM_PHASES * MAX_PHASE_LEN + DRAIN_CYCLES + 1);
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        last_was_write = 1'b1;
        for (int p = 0; p < NUM_PHASES; p++) begin
            // a switch is one cycle with ordinary stages on both sides
            if (!last_was_write && chance(25)) begin
                stage = STAGE_WRITE_TO_MEM;
                len   = 1;
            end else begin
                stage = stage_t'(3'($urandom_range(0, 6)));
                len   = int'($urandom_range(2, MAX_PHASE_LEN));
            end
            last_was_write = (stage == STAGE_WRITE_TO_MEM);
            cfg = '{weight: LINK_BIT_WIDTH'($urandom_range(0, MAX_WEIGHT)),
                    boundary: boundary_t'(2'($urandom))};
            repeat (len) drive_cycle(stage, cfg);
        end
        repeat (DRAIN_CYCLES) drive_cycle(STAGE_IDLE, '0);
        @(negedge clk);
        finish_run();
    end

    initial begin
        wait (timed_out === 1'b1);
        finish_run();
    end

endmodule

// File: neighbor_link.f
rtl/neighbor_link_pkg.sv
rtl/context_ram.sv
rtl/context_store.sv
rtl/link_control.sv
rtl/link_growth.sv
rtl/neighbor_link.sv
dv/link_checker.sv
dv/neighbor_link_tb.sv

// File: rtl/context_ram.sv
module context_ram
    import neighbor_link_pkg::*;
(
    input  logic                          clk,
    input  logic                          we,
    input  logic [CONTEXT_ADDR_WIDTH-1:0] addr,
    input  link_context_t                 wdata,
    output link_context_t                 rdata
);

    link_context_t mem [NUM_CONTEXTS];

    // unwritten slots read back as an empty context
    initial begin
        for (int i = 0; i < NUM_CONTEXTS; i++) begin
            mem[i] = '0;
        end
        rdata = '0;
    end

    // no-change mode where the output holds while writing
    always @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end else begin
            rdata <= mem[addr];
        end
    end

endmodule

// File: rtl/context_store.sv
module context_store
    import neighbor_link_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  stage_t        stage,
    input  logic          do_not_store,
    input  link_context_t state,
    output link_context_t loaded
);

    logic [CONTEXT_ADDR_WIDTH-1:0] write_slot;
    logic [CONTEXT_ADDR_WIDTH-1:0] read_slot;
    logic [CONTEXT_ADDR_WIDTH-1:0] addr;
    logic                          switching;
    logic                          we;

    // round-robin over every slot
    function automatic logic [CONTEXT_ADDR_WIDTH-1:0] next_slot(
        input logic [CONTEXT_ADDR_WIDTH-1:0] slot
    );
        if (slot == CONTEXT_ADDR_WIDTH'(NUM_CONTEXTS - 1)) begin
            return '0;
        end
        return slot + 1'b1;
    endfunction

    assign switching = (stage == STAGE_WRITE_TO_MEM);
    assign we        = switching && !do_not_store;

    // write slot during the switch and read slot otherwise to keep rdata primed
    assign addr = switching ? write_slot : read_slot;

    // read slot runs one ahead of the write slot
    always_ff @(posedge clk) begin
        if (reset) begin
            write_slot <= '0;
            read_slot  <= CONTEXT_ADDR_WIDTH'(1);
        end else if (we) begin
            write_slot <= next_slot(write_slot);
            read_slot  <= next_slot(read_slot);
        end
    end

    context_ram u_ram (
        .clk   (clk),
        .we    (we),
        .addr  (addr),
        .wdata (state),
        .rdata (loaded)
    );

endmodule

// File: rtl/link_control.sv
module link_control
    import neighbor_link_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  stage_t        global_stage,
    input  link_config_t  config_in,
    input  exposed_data_t a_input_data,
    input  exposed_data_t b_input_data,
    output stage_t        stage,
    output link_config_t  cfg,
    output exposed_data_t a_output_data,
    output exposed_data_t b_output_data
);

    logic normal_edge;

    // stage follows the global controller one cycle late
    always_ff @(posedge clk) begin
        if (reset) begin
            stage <= STAGE_IDLE;
        end else begin
            stage <= global_stage;
        end
    end

    // weight and kind sampled every cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            cfg <= '0;
        end else begin
            cfg <= config_in;
        end
    end

    assign normal_edge = (cfg.boundary == BOUNDARY_NONE);

    // each end sees the other end's cluster
    // boundary, absent and fusion edges expose nothing
    always_comb begin
        if (normal_edge) begin
            a_output_data = b_input_data;
            b_output_data = a_input_data;
        end else begin
            a_output_data = '0;
            b_output_data = '0;
        end
    end

endmodule

// File: rtl/link_growth.sv
module link_growth
    import neighbor_link_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  stage_t        stage,
    input  link_config_t  cfg,
    input  logic          a_increase,
    input  logic          b_increase,
    input  logic          a_is_error_in,
    input  logic          b_is_error_in,
    input  logic          is_error_systolic_in,
    input  logic          do_not_store,
    input  logic          reset_edge,
    input  link_context_t loaded,
    output link_context_t state,
    output logic          fully_grown,
    output logic          is_boundary,
    output logic          is_error
);

    logic [LINK_BIT_WIDTH-1:0]   growth;
    logic [GROWTH_SUM_WIDTH-1:0] growth_sum;
    logic [LINK_BIT_WIDTH-1:0]   growth_next;
    logic                        error_next;
    logic                        switching;

    assign switching = (stage == STAGE_WRITE_TO_MEM);

    // raw growth per edge kind
    always_comb begin
        case (cfg.boundary)
            BOUNDARY_NONE, BOUNDARY_FUSION: begin
                growth_sum = GROWTH_SUM_WIDTH'(growth) + GROWTH_SUM_WIDTH'(a_increase)
                           + GROWTH_SUM_WIDTH'(b_increase);
            end
            BOUNDARY_TOUCH: begin
                growth_sum = GROWTH_SUM_WIDTH'(growth) + GROWTH_SUM_WIDTH'(a_increase);
            end
            default: begin
                growth_sum = '0;
            end
        endcase
    end

    // saturate at the edge weight
    assign growth_next = (growth_sum > GROWTH_SUM_WIDTH'(cfg.weight)) ? cfg.weight
                                                                      : growth_sum[LINK_BIT_WIDTH-1:0];

    // systolic result overrides the end flags in RESULT_VALID
    always_comb begin
        case (cfg.boundary)
            BOUNDARY_NONE, BOUNDARY_FUSION: begin
                error_next = (stage == STAGE_RESULT_VALID) ? is_error_systolic_in
                                                           : (a_is_error_in | b_is_error_in);
            end
            BOUNDARY_TOUCH: begin
                error_next = (stage == STAGE_RESULT_VALID) ? is_error_systolic_in
                                                           : a_is_error_in;
            end
            default: begin
                error_next = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            growth   <= '0;
            is_error <= 1'b0;
        end else if (switching) begin
            if (!do_not_store) begin
                // next round comes back from the context memory
                growth   <= loaded.growth;
                is_error <= loaded.is_error;
            end else begin
                // bypass keeps growth and clears error
                if (reset_edge) begin
                    growth <= '0;
                end
                is_error <= 1'b0;
            end
        end else begin
            growth   <= reset_edge ? '0 : growth_next;
            is_error <= error_next;
        end
    end

    assign state = {growth, is_error};

    // an absent edge never counts as grown
    assign fully_grown = (growth >= cfg.weight) && (cfg.boundary != BOUNDARY_ABSENT);
    assign is_boundary = fully_grown
                      && ((cfg.boundary == BOUNDARY_TOUCH) || (cfg.boundary == BOUNDARY_FUSION));

endmodule

// File: rtl/neighbor_link.sv
module neighbor_link
    import neighbor_link_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  stage_t        global_stage,
    input  link_config_t  config_in,
    input  logic          a_increase,
    input  logic          b_increase,
    input  logic          a_is_error_in,
    input  logic          b_is_error_in,
    input  logic          is_error_systolic_in,
    input  logic          do_not_store,
    input  logic          reset_edge,
    input  exposed_data_t a_input_data,
    input  exposed_data_t b_input_data,
    output logic          fully_grown,
    output logic          is_boundary,
    output logic          is_error,
    output link_config_t  config_out,
    output exposed_data_t a_output_data,
    output exposed_data_t b_output_data
);

    stage_t        stage;
    link_context_t state;
    link_context_t loaded;

    // registered config doubles as the edge's config_out
    link_control u_control (
        .clk           (clk),
        .reset         (reset),
        .global_stage  (global_stage),
        .config_in     (config_in),
        .a_input_data  (a_input_data),
        .b_input_data  (b_input_data),
        .stage         (stage),
        .cfg           (config_out),
        .a_output_data (a_output_data),
        .b_output_data (b_output_data)
    );

    link_growth u_growth (
        .clk                  (clk),
        .reset                (reset),
        .stage                (stage),
        .cfg                  (config_out),
        .a_increase           (a_increase),
        .b_increase           (b_increase),
        .a_is_error_in        (a_is_error_in),
        .b_is_error_in        (b_is_error_in),
        .is_error_systolic_in (is_error_systolic_in),
        .do_not_store         (do_not_store),
        .reset_edge           (reset_edge),
        .loaded               (loaded),
        .state                (state),
        .fully_grown          (fully_grown),
        .is_boundary          (is_boundary),
        .is_error             (is_error)
    );

    // per-round growth and error saved locally
    context_store u_store (
        .clk          (clk),
        .reset        (reset),
        .stage        (stage),
        .do_not_store (do_not_store),
        .state        (state),
        .loaded       (loaded)
    );

endmodule

// File: rtl/neighbor_link_pkg.sv
package neighbor_link_pkg;

    // cluster root address width
    localparam int ADDRESS_WIDTH = 6;

    // edge weight and growth counter
    localparam int MAX_WEIGHT = 2;
    localparam int LINK_BIT_WIDTH = $clog2(MAX_WEIGHT + 1);

    // growth plus both increases, before saturation
    localparam int GROWTH_SUM_WIDTH = $clog2(MAX_WEIGHT + 3);

    // local context memory
    localparam int NUM_CONTEXTS = 4;
    localparam int CONTEXT_ADDR_WIDTH = $clog2(NUM_CONTEXTS);

    localparam int STAGE_WIDTH = 3;

    // decoder stages shared with the whole grid
    typedef enum logic [STAGE_WIDTH-1:0] {
        STAGE_IDLE                = 3'd0,
        STAGE_PARAMETERS_LOADING  = 3'd1,
        STAGE_MEASUREMENT_LOADING = 3'd2,
        STAGE_GROW                = 3'd3,
        STAGE_MERGE               = 3'd4,
        STAGE_PEELING             = 3'd5,
        STAGE_RESULT_VALID        = 3'd6,
        STAGE_WRITE_TO_MEM        = 3'd7
    } stage_t;

    // edge kinds
    typedef enum logic [1:0] {
        // ordinary edge between two PEs
        BOUNDARY_NONE   = 2'd0,
        // only the a end is a real PE
        BOUNDARY_TOUCH  = 2'd1,
        // edge does not exist
        BOUNDARY_ABSENT = 2'd2,
        // grows from both ends but reports like a boundary
        BOUNDARY_FUSION = 2'd3
    } boundary_t;

    // per-edge configuration reloaded every cycle
    typedef struct packed {
        logic [LINK_BIT_WIDTH-1:0] weight;
        boundary_t                 boundary;
    } link_config_t;

    // state saved per decoding round
    typedef struct packed {
        logic [LINK_BIT_WIDTH-1:0] growth;
        logic                      is_error;
    } link_context_t;

    // cluster data exposed by a PE to its neighbour
    typedef struct packed {
        logic [ADDRESS_WIDTH-1:0] root;
        logic                     odd;
        logic                     busy;
        logic                     valid;
    } exposed_data_t;

endpackage

// File: run_sim.sh
#!/usr/bin/env bash
# build with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing -Wno-fatal --top-module neighbor_link_tb -f neighbor_link.f \
    -o neighbor_link_sim > build.log 2>&1 \
    && ./obj_dir/neighbor_link_sim > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -qx "sim passed" sim.log && exit 0 || exit 1
